// File: icache_cfg_pkg.sv
/* geometry of the two-way instruction cache, shared by the RTL and the testbench
   address split is tag[31:9], index[8:3], word select bit 2 */
package icache_cfg_pkg;

    localparam int ADDR_W   = 32;
    localparam int INST_W   = 32;
    localparam int LINE_W   = 64;  // two instructions per line

    localparam int NUM_SETS = 64;
    localparam int INDEX_W  = 6;
    localparam int TAG_W    = 23;
    localparam int NUM_WAYS = 2;

    // replacement ages
    localparam int AGE_W    = 3;
    localparam int AGE_MAX  = 7;

    // bit positions inside a fetch address
    localparam int INDEX_LSB = ADDR_W - TAG_W - INDEX_W;  // 3
    localparam int TAG_LSB   = INDEX_LSB + INDEX_W;       // 9
    localparam int WORD_SEL  = 2;                         // upper or lower half of a line

endpackage

// File: icache_types_pkg.sv
/* request, response and array-write types of the instruction cache */
package icache_types_pkg;

    typedef logic [icache_cfg_pkg::ADDR_W-1:0]   addr_t;
    typedef logic [icache_cfg_pkg::INDEX_W-1:0]  index_t;
    typedef logic [icache_cfg_pkg::TAG_W-1:0]    tag_t;
    typedef logic [icache_cfg_pkg::LINE_W-1:0]   line_t;
    typedef logic [icache_cfg_pkg::INST_W-1:0]   inst_t;
    typedef logic                                way_t;
    typedef logic [icache_cfg_pkg::NUM_WAYS-1:0] way_mask_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
    } tag_entry_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic  valid;
        inst_t data;
    } fetch_rsp_t;

    typedef struct packed {
        logic  read;
        addr_t addr;  // line aligned
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        line_t data;
    } mem_rsp_t;

    // one write into the tag and data arrays, fence or fill
    typedef struct packed {
        logic       en;
        way_mask_t  mask;
        index_t     index;
        tag_entry_t entry;
        line_t      line;
    } arr_wr_t;

    typedef struct packed {
        logic      hit;
        way_t      hit_way;
        way_mask_t valid;
        inst_t     inst;
    } lookup_t;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        COMPARE,
        MISS
    } ctrl_state_e;

endpackage

// File: icache_sram.sv
/* behavioural single-port synchronous RAM, one entry per set
   read data shows up the cycle after en_i without we_i */
`timescale 1ns/1ps

module icache_sram #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = icache_cfg_pkg::NUM_SETS
) (
    input  logic                     clk,
    input  logic                     en_i,
    input  logic                     we_i,
    input  icache_types_pkg::index_t addr_i,
    input  entry_t                   wdata_i,
    output entry_t                   rdata_o
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i];  // old data kept while writing
            end
        end
    end

    // enable settles once reset has reached the controller and stays known
    a_en_known: assert property (
        @(posedge clk) !$isunknown($past(en_i)) |-> !$isunknown(en_i)
    ) else $error("sram enable went unknown");

endmodule

// File: icache_lookup.sv
/* tag and data arrays of both ways with the tag compare
   result is valid the cycle after rd_en_i, while the fetch address is held */
`timescale 1ns/1ps

module icache_lookup (
    input  logic                        clk,
    input  icache_types_pkg::addr_t     fetch_addr_i,
    input  logic                        rd_en_i,
    input  icache_types_pkg::arr_wr_t   arr_wr_i,
    output icache_types_pkg::lookup_t   lookup_o
);

    icache_types_pkg::tag_t       fetch_tag;
    icache_types_pkg::index_t     ram_addr;
    icache_types_pkg::tag_entry_t rd_entry [icache_cfg_pkg::NUM_WAYS];
    icache_types_pkg::line_t      rd_line  [icache_cfg_pkg::NUM_WAYS];
    icache_types_pkg::way_mask_t  way_hit;
    icache_types_pkg::way_mask_t  way_valid;
    icache_types_pkg::way_t       hit_way;
    icache_types_pkg::line_t      hit_line;

    assign fetch_tag = fetch_addr_i[icache_cfg_pkg::TAG_LSB +: icache_cfg_pkg::TAG_W];

    // writes carry their own set number
    assign ram_addr = arr_wr_i.en ? arr_wr_i.index
                                  : fetch_addr_i[icache_cfg_pkg::INDEX_LSB +:
                                                 icache_cfg_pkg::INDEX_W];

    for (genvar w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin : g_way
        logic way_we;

        assign way_we = arr_wr_i.en & arr_wr_i.mask[w];

        icache_sram #(
            .entry_t (icache_types_pkg::tag_entry_t),
            .DEPTH   (icache_cfg_pkg::NUM_SETS)
        ) tag_ram_i (
            .clk     (clk),
            .en_i    (rd_en_i | way_we),
            .we_i    (way_we),
            .addr_i  (ram_addr),
            .wdata_i (arr_wr_i.entry),
            .rdata_o (rd_entry[w])
        );

        icache_sram #(
            .entry_t (icache_types_pkg::line_t),
            .DEPTH   (icache_cfg_pkg::NUM_SETS)
        ) data_ram_i (
            .clk     (clk),
            .en_i    (rd_en_i | way_we),
            .we_i    (way_we),
            .addr_i  (ram_addr),
            .wdata_i (arr_wr_i.line),
            .rdata_o (rd_line[w])
        );

        assign way_valid[w] = rd_entry[w].valid;
        assign way_hit[w]   = rd_entry[w].valid && (rd_entry[w].tag == fetch_tag);
    end

    assign hit_way  = way_hit[1];
    assign hit_line = rd_line[hit_way];

    always_comb begin
        lookup_o.hit     = |way_hit;
        lookup_o.hit_way = hit_way;
        lookup_o.valid   = way_valid;
        if (fetch_addr_i[icache_cfg_pkg::WORD_SEL]) begin
            lookup_o.inst = hit_line[icache_cfg_pkg::LINE_W-1 -: icache_cfg_pkg::INST_W];
        end else begin
            lookup_o.inst = hit_line[icache_cfg_pkg::INST_W-1:0];
        end
    end

    // refill picks one victim, so a tag never lands in both ways
    a_one_hit: assert property (
        @(posedge clk) !$isunknown(way_hit) |-> $onehot0(way_hit)
    ) else $error("tag hit in more than one way");

endmodule

// File: icache_victim_select.sv
/* per-set, per-way age counters and the refill victim choice
   invalid ways go first, otherwise the older way, ties to way 0 */
`timescale 1ns/1ps

module icache_victim_select (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  icache_types_pkg::index_t    index_i,
    input  logic                        hit_i,
    input  icache_types_pkg::way_t      hit_way_i,
    input  icache_types_pkg::arr_wr_t   fill_i,
    input  icache_types_pkg::way_mask_t way_valid_i,
    output icache_types_pkg::way_t      victim_way_o
);

    logic [icache_cfg_pkg::AGE_W-1:0] age_q [icache_cfg_pkg::NUM_SETS][icache_cfg_pkg::NUM_WAYS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int s = 0; s < icache_cfg_pkg::NUM_SETS; s++) begin
                for (int w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin
                    age_q[s][w] <= '0;
                end
            end
        end else begin
            if (hit_i) begin
                // every line grows older on a hit
                for (int s = 0; s < icache_cfg_pkg::NUM_SETS; s++) begin
                    for (int w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin
                        if (age_q[s][w] != icache_cfg_pkg::AGE_W'(icache_cfg_pkg::AGE_MAX)) begin
                            age_q[s][w] <= age_q[s][w] + 1'b1;
                        end
                    end
                end
                age_q[index_i][hit_way_i] <= '0;  // last assignment wins
            end
            if (fill_i.en) begin
                for (int w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin
                    if (fill_i.mask[w]) begin
                        age_q[fill_i.index][w] <= '0;
                    end
                end
            end
        end
    end

    always_comb begin
        if (!way_valid_i[0]) begin
            victim_way_o = 1'b0;
        end else if (!way_valid_i[1]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = (age_q[index_i][1] > age_q[index_i][0]);
        end
    end

endmodule

// File: icache_ctrl.sv
/* fetch FSM of the instruction cache with the fence sweep
   drives the array reads and muxes fence writes with refill fills */
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  icache_types_pkg::fetch_req_t   fetch_req_i,
    input  logic                           fence_i,
    input  icache_types_pkg::lookup_t      lookup_i,
    input  icache_types_pkg::arr_wr_t      fill_i,
    output logic                           rd_en_o,
    output icache_types_pkg::arr_wr_t      arr_wr_o,
    output logic                           hit_o,
    output logic                           refill_start_o,
    output icache_types_pkg::fetch_rsp_t   fetch_rsp_o
);

    icache_types_pkg::ctrl_state_e state_q;
    icache_types_pkg::ctrl_state_e state_d;
    logic [icache_cfg_pkg::INDEX_W:0] fence_cnt_q;  // msb set once all sets are swept
    logic                             fence_active;
    logic                             compare_hit;

    assign fence_active = fence_i & ~fence_cnt_q[icache_cfg_pkg::INDEX_W];
    assign compare_hit  = (state_q == icache_types_pkg::COMPARE) && lookup_i.hit;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fence_cnt_q <= '0;
        end else if (!fence_i) begin
            fence_cnt_q <= '0;
        end else if (fence_active) begin
            fence_cnt_q <= fence_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= icache_types_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            icache_types_pkg::IDLE: begin
                if (fetch_req_i.valid && !fence_i) begin
                    state_d = icache_types_pkg::READ;
                end
            end
            icache_types_pkg::READ: state_d = icache_types_pkg::COMPARE;
            icache_types_pkg::COMPARE: begin
                state_d = lookup_i.hit ? icache_types_pkg::IDLE : icache_types_pkg::MISS;
            end
            icache_types_pkg::MISS: begin
                if (fill_i.en) begin
                    state_d = icache_types_pkg::READ;  // look up again after the fill
                end
            end
            default: state_d = icache_types_pkg::IDLE;
        endcase
    end

    // fence clears set k of both ways in the k-th cycle
    always_comb begin
        if (fence_i) begin
            arr_wr_o.en    = fence_active;
            arr_wr_o.mask  = '1;
            arr_wr_o.index = fence_cnt_q[icache_cfg_pkg::INDEX_W-1:0];
            arr_wr_o.entry = '0;
            arr_wr_o.line  = '0;
        end else begin
            arr_wr_o = fill_i;
        end
    end

    assign rd_en_o          = (state_q == icache_types_pkg::READ);
    assign hit_o            = compare_hit;
    assign refill_start_o   = (state_q == icache_types_pkg::COMPARE) && !lookup_i.hit;
    assign fetch_rsp_o.valid = compare_hit;
    assign fetch_rsp_o.data  = lookup_i.inst;

    // an unfenced array read leaves the hit flag unknown
    a_state_legal: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !$isunknown(state_q)
    ) else $error("controller state went unknown");

    // core only fences with no fetch in flight
    a_fence_idle: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        $rose(fence_i) |-> state_q == icache_types_pkg::IDLE
    ) else $error("fence raised outside IDLE");

endmodule

// File: icache_refill.sv
/* line refill towards memory, one aligned read per miss
   the returned line is written straight into the victim way */
`timescale 1ns/1ps

module icache_refill (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        start_i,
    input  icache_types_pkg::addr_t     fetch_addr_i,
    input  icache_types_pkg::way_t      victim_way_i,
    output icache_types_pkg::mem_req_t  mem_req_o,
    input  icache_types_pkg::mem_rsp_t  mem_rsp_i,
    output icache_types_pkg::arr_wr_t   fill_o
);

    logic                        pend_q;
    icache_types_pkg::addr_t     addr_q;
    icache_types_pkg::way_t      way_q;
    icache_types_pkg::way_mask_t way_mask;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pend_q <= 1'b0;
        end else if (start_i) begin
            pend_q <= 1'b1;
        end else if (mem_rsp_i.valid) begin
            pend_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            addr_q <= {fetch_addr_i[icache_cfg_pkg::ADDR_W-1:icache_cfg_pkg::INDEX_LSB],
                       icache_cfg_pkg::INDEX_LSB'(0)};
            way_q  <= victim_way_i;
        end
    end

    always_comb begin
        way_mask        = '0;
        way_mask[way_q] = 1'b1;
    end

    // read drops in the response cycle
    assign mem_req_o.read = pend_q & ~mem_rsp_i.valid;
    assign mem_req_o.addr = addr_q;

    assign fill_o.en          = pend_q & mem_rsp_i.valid;
    assign fill_o.mask        = way_mask;
    assign fill_o.index       = addr_q[icache_cfg_pkg::INDEX_LSB +: icache_cfg_pkg::INDEX_W];
    assign fill_o.entry.valid = 1'b1;
    assign fill_o.entry.tag   = addr_q[icache_cfg_pkg::TAG_LSB +: icache_cfg_pkg::TAG_W];
    assign fill_o.line        = mem_rsp_i.data;

    a_rsp_pending: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        mem_rsp_i.valid |-> pend_q
    ) else $error("memory response without a pending read");

endmodule

// File: icache_top.sv
/* two-way set-associative instruction cache, core fetch port on one side
   and a single line-read memory port on the other */
`timescale 1ns/1ps

module icache_top (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  icache_types_pkg::fetch_req_t  fetch_req_i,
    input  logic                          fence_i,
    output icache_types_pkg::fetch_rsp_t  fetch_rsp_o,
    output icache_types_pkg::mem_req_t    mem_req_o,
    input  icache_types_pkg::mem_rsp_t    mem_rsp_i
);

    logic                        rd_en;
    logic                        hit;
    logic                        refill_start;
    icache_types_pkg::arr_wr_t   arr_wr;
    icache_types_pkg::arr_wr_t   fill;
    icache_types_pkg::lookup_t   lookup;
    icache_types_pkg::way_t      victim_way;

    icache_lookup icache_lookup_i (
        .clk          (clk),
        .fetch_addr_i (fetch_req_i.addr),
        .rd_en_i      (rd_en),
        .arr_wr_i     (arr_wr),
        .lookup_o     (lookup)
    );

    icache_ctrl icache_ctrl_i (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .fetch_req_i    (fetch_req_i),
        .fence_i        (fence_i),
        .lookup_i       (lookup),
        .fill_i         (fill),
        .rd_en_o        (rd_en),
        .arr_wr_o       (arr_wr),
        .hit_o          (hit),
        .refill_start_o (refill_start),
        .fetch_rsp_o    (fetch_rsp_o)
    );

    icache_victim_select icache_victim_select_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .index_i      (fetch_req_i.addr[icache_cfg_pkg::INDEX_LSB +: icache_cfg_pkg::INDEX_W]),
        .hit_i        (hit),
        .hit_way_i    (lookup.hit_way),
        .fill_i       (fill),
        .way_valid_i  (lookup.valid),
        .victim_way_o (victim_way)
    );

    icache_refill icache_refill_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .start_i      (refill_start),
        .fetch_addr_i (fetch_req_i.addr),
        .victim_way_i (victim_way),
        .mem_req_o    (mem_req_o),
        .mem_rsp_i    (mem_rsp_i),
        .fill_o       (fill)
    );

endmodule

// File: tb_clk_gen.sv
/* clock and reset source for the cache testbench, 20 ns period,
   reset held low for the first three cycles */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);  // release away from the active edge
        arst_n_o = 1'b1;
    end

endmodule

// File: tb_icache.sv
/* testbench of the instruction cache with memory model, reference model and watchdog
   inputs change on the falling edge, outputs are checked there too */
`timescale 1ns/1ps

module tb_icache;

    localparam int NUM_FETCHES    = 311;
    localparam int NUM_FENCES     = 2;
    localparam int TIMEOUT_CYCLES = 200 * NUM_FETCHES + 100 * NUM_FENCES;

    logic                         clk;
    logic                         arst_n;
    icache_types_pkg::fetch_req_t fetch_req;
    logic                         fence_i;
    icache_types_pkg::fetch_rsp_t fetch_rsp_o;
    icache_types_pkg::mem_req_t   mem_req_o;
    icache_types_pkg::mem_rsp_t   mem_rsp;

    // reference state, same geometry as the cache
    logic                   ref_valid [icache_cfg_pkg::NUM_SETS][icache_cfg_pkg::NUM_WAYS];
    icache_types_pkg::tag_t ref_tag   [icache_cfg_pkg::NUM_SETS][icache_cfg_pkg::NUM_WAYS];
    int                     ref_age   [icache_cfg_pkg::NUM_SETS][icache_cfg_pkg::NUM_WAYS];

    icache_types_pkg::fetch_rsp_t exp_q[$];
    string                        name_q[$];
    string                        cur_name = "reset";
    icache_types_pkg::addr_t      cur_addr = '0;
    int                           mem_reads = 0;
    logic [31:0]                  stim_seed = 32'd87840;
    logic [31:0]                  mem_seed = 32'd87840;

    tb_clk_gen clk_gen_i (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    icache_top icache_top_i (
        .clk         (clk),
        .arst_n_i    (arst_n),
        .fetch_req_i (fetch_req),
        .fence_i     (fence_i),
        .fetch_rsp_o (fetch_rsp_o),
        .mem_req_o   (mem_req_o),
        .mem_rsp_i   (mem_rsp)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // line contents as a hash of the aligned address
    function automatic icache_types_pkg::line_t line_data(input icache_types_pkg::addr_t a);
        logic [31:0] h;
        h = a * 32'h9e3779b1;
        return {h ^ {a[15:0], a[31:16]}, ~a ^ (h >> 7)};
    endfunction

    function automatic icache_types_pkg::inst_t expected_inst(input icache_types_pkg::addr_t a);
        icache_types_pkg::line_t line;
        line = line_data({a[31:3], 3'b000});
        return a[2] ? line[63:32] : line[31:0];
    endfunction

    task automatic report_fail();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_rsp(input string name, input icache_types_pkg::fetch_rsp_t exp,
                             input icache_types_pkg::fetch_rsp_t act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            report_fail();
        end
    endtask

    task automatic check_mem_req(input string name, input icache_types_pkg::mem_req_t exp,
                                 input icache_types_pkg::mem_req_t act);
        if (act !== exp) begin
            $display("Mismatch %s memory read: expected %h, actual %h", name, exp, act);
            report_fail();
        end
    endtask

    task automatic check_miss(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Mismatch %s memory reads: expected %0d, actual %0d", name, exp, act);
            report_fail();
        end
    endtask

    function automatic int find_way(input icache_types_pkg::addr_t a);
        for (int w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin
            if (ref_valid[a[8:3]][w] && ref_tag[a[8:3]][w] == a[31:9]) begin
                return w;
            end
        end
        return -1;
    endfunction

    // a hit ages every line, then clears the hit way
    task automatic age_touch(input int idx, input int way);
        for (int s = 0; s < icache_cfg_pkg::NUM_SETS; s++) begin
            for (int w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin
                if (ref_age[s][w] < icache_cfg_pkg::AGE_MAX) begin
                    ref_age[s][w]++;
                end
            end
        end
        ref_age[idx][way] = 0;
    endtask

    task automatic predict_access(input icache_types_pkg::addr_t a, output int reads);
        int idx;
        int way;
        idx = a[8:3];
        way = find_way(a);
        reads = 0;
        if (way < 0) begin
            if (!ref_valid[idx][0]) begin
                way = 0;
            end else if (!ref_valid[idx][1]) begin
                way = 1;
            end else begin
                way = (ref_age[idx][1] > ref_age[idx][0]) ? 1 : 0;
            end
            ref_valid[idx][way] = 1'b1;
            ref_tag[idx][way]   = a[31:9];
            ref_age[idx][way]   = 0;
            reads = 1;
        end
        age_touch(idx, way);  // refetch after a fill hits too
    endtask

    task automatic run_fence();
        @(negedge clk);
        fence_i = 1'b1;
        repeat (icache_cfg_pkg::NUM_SETS + 2) @(negedge clk);
        fence_i = 1'b0;
        for (int s = 0; s < icache_cfg_pkg::NUM_SETS; s++) begin
            ref_valid[s][0] = 1'b0;
            ref_valid[s][1] = 1'b0;
        end
    endtask

    task automatic do_fetch(input string name, input icache_types_pkg::addr_t addr);
        int                           exp_reads;
        int                           reads_before;
        icache_types_pkg::fetch_rsp_t exp_rsp;
        exp_rsp.valid = 1'b1;
        exp_rsp.data  = expected_inst(addr);
        predict_access(addr, exp_reads);
        @(negedge clk);
        cur_name     = name;
        cur_addr     = addr;
        reads_before = mem_reads;
        exp_q.push_back(exp_rsp);
        name_q.push_back(name);
        fetch_req.valid = 1'b1;
        fetch_req.addr  = addr;
        do @(negedge clk); while (fetch_rsp_o.valid !== 1'b1);
        fetch_req.valid = 1'b0;  // address stays until the next request
        check_miss(name, exp_reads, mem_reads - reads_before);
    endtask

    // compare every response against the queued expectation
    always @(negedge clk) begin
        if (arst_n && fetch_rsp_o.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Error: response arrived with no fetch outstanding");
                report_fail();
            end else begin
                check_rsp(name_q.pop_front(), exp_q.pop_front(), fetch_rsp_o);
            end
        end
    end

    initial begin : memory_model
        int                         delay;
        icache_types_pkg::mem_req_t exp_req;
        forever begin
            @(negedge clk);
            if (arst_n && mem_req_o.read === 1'b1) begin
                exp_req.read = 1'b1;
                exp_req.addr = {cur_addr[31:3], 3'b000};
                check_mem_req(cur_name, exp_req, mem_req_o);
                mem_reads++;
                mem_seed = lcg_next(mem_seed);
                delay    = 1 + int'(mem_seed[17:16]);  // 1 to 4 cycles
                repeat (delay) @(negedge clk);
                mem_rsp.valid = 1'b1;
                mem_rsp.data  = line_data(mem_req_o.addr);
                @(negedge clk);
                mem_rsp = '0;
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        report_fail();
    end

    initial begin : stimulus
        icache_types_pkg::addr_t a_addr;
        icache_types_pkg::addr_t b_addr;
        icache_types_pkg::addr_t c_addr;
        icache_types_pkg::addr_t addr;
        logic [15:0]             r;
        int                      set_pool [4];
        fetch_req = '0;
        fence_i   = 1'b0;
        mem_rsp   = '0;
        set_pool  = '{0, 1, 5, 63};
        a_addr    = 32'h0000_1000;
        b_addr    = 32'h0000_1200;  // same set, next tag
        c_addr    = 32'h0000_1400;
        for (int s = 0; s < icache_cfg_pkg::NUM_SETS; s++) begin
            for (int w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
                ref_age[s][w]   = 0;
            end
        end
        @(posedge arst_n);
        @(negedge clk);
        if (fetch_rsp_o.valid !== 1'b0 || mem_req_o.read !== 1'b0) begin
            $display("Error: response or memory read active right after reset");
            report_fail();
        end
        run_fence();
        do_fetch("first miss", a_addr);
        do_fetch("same line hit", a_addr + 32'd4);
        do_fetch("second tag fill", b_addr);
        do_fetch("first tag resident", a_addr);
        do_fetch("second tag resident", b_addr);
        do_fetch("third tag evict", c_addr);
        if (find_way(a_addr) >= 0) begin
            do_fetch("survivor hit", a_addr);
            do_fetch("evicted miss", b_addr);
        end else begin
            do_fetch("survivor hit", b_addr);
            do_fetch("evicted miss", a_addr);
        end
        run_fence();
        do_fetch("fence miss a", a_addr);
        do_fetch("fence miss b", b_addr + 32'd4);
        do_fetch("fence miss c", c_addr);
        for (int i = 0; i < 300; i++) begin
            stim_seed = lcg_next(stim_seed);
            r         = stim_seed[31:16];
            addr      = 32'h0001_0000 + (int'(r % 3) << 9) + (set_pool[r[5:4]] << 3)
                        + (int'(r[8]) << 2);
            do_fetch($sformatf("random %0d", i), addr);
        end
        repeat (2) @(negedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: build.f
icache_cfg_pkg.sv
icache_types_pkg.sv
icache_sram.sv
icache_lookup.sv
icache_victim_select.sv
icache_ctrl.sv
icache_refill.sv
icache_top.sv
tb_clk_gen.sv
tb_icache.sv
